// File: rtl/pkm_config.svh
`ifndef PKM_CONFIG_SVH
`define PKM_CONFIG_SVH

// ====================
// field widths
// ====================
`define PKM_MONEY_W       14
`define PKM_COUNT_W       4
`define PKM_STONE_W       2
`define PKM_ID_W          8
`define PKM_DATA_W        16
`define PKM_REC_W         64

`define PKM_COUNT_MAX     15   // item counter ceiling

// shop prices, buying
`define PKM_BUY_BERRY     16
`define PKM_BUY_MEDICINE  128
`define PKM_BUY_CANDY     300
`define PKM_BUY_BRACER    64
`define PKM_BUY_STONE     800

// shop prices, selling
`define PKM_SELL_BERRY    12
`define PKM_SELL_MEDICINE 96
`define PKM_SELL_CANDY    225
`define PKM_SELL_BRACER   48
`define PKM_SELL_STONE    600

`endif

// File: rtl/pkm_pkg.sv
`include "pkm_config.svh"

package pkm_pkg;

	typedef logic [`PKM_MONEY_W-1:0] money_t;
	typedef logic [`PKM_COUNT_W-1:0] count_t;
	typedef logic [`PKM_STONE_W-1:0] stone_t;  // 0 none, 1 water, 2 fire, 3 thunder
	typedef logic [`PKM_ID_W-1:0]    player_id_t;

	// berry, medicine, candy, bracer, stone, money from msb down
	typedef logic [4*`PKM_COUNT_W+`PKM_STONE_W+`PKM_MONEY_W-1:0] bag_t;
	typedef logic [`PKM_REC_W-1:0] record_t;   // monster word over bag word

	typedef enum logic [3:0] {
		ACT_NONE    = 4'd0,
		ACT_BUY     = 4'd1,
		ACT_SELL    = 4'd2,
		ACT_DEPOSIT = 4'd4,
		ACT_CHECK   = 4'd8
	} action_e;

	typedef enum logic [3:0] {
		ITEM_NONE          = 4'd0,
		ITEM_BERRY         = 4'd1,
		ITEM_MEDICINE      = 4'd2,
		ITEM_CANDY         = 4'd3,
		ITEM_BRACER        = 4'd4,
		ITEM_WATER_STONE   = 4'd5,
		ITEM_FIRE_STONE    = 4'd6,
		ITEM_THUNDER_STONE = 4'd7
	} item_e;

	typedef enum logic [3:0] {
		ERR_NONE    = 4'd0,
		ERR_MONEY   = 4'd1,   // out of money
		ERR_FULL    = 4'd2,   // bag is full
		ERR_NO_ITEM = 4'd3    // not having item
	} err_e;

	typedef enum logic [1:0] {ST_IDLE, ST_WAIT_ARG, ST_EXEC, ST_REPORT} state_e;

endpackage

// File: rtl/trade_price.sv
`timescale 1ns/1ps
`include "pkm_config.svh"

module trade_price (
	input  pkm_pkg::item_e  item,
	input  logic            sell,   // 1 picks the selling price
	output pkm_pkg::money_t price
);
	import pkm_pkg::*;

	money_t buy_p;
	money_t sell_p;

	// one lookup per direction, stones all cost the same
	always_comb begin
		case (item)
			ITEM_BERRY: begin
				buy_p  = money_t'(`PKM_BUY_BERRY);
				sell_p = money_t'(`PKM_SELL_BERRY);
			end
			ITEM_MEDICINE: begin
				buy_p  = money_t'(`PKM_BUY_MEDICINE);
				sell_p = money_t'(`PKM_SELL_MEDICINE);
			end
			ITEM_CANDY: begin
				buy_p  = money_t'(`PKM_BUY_CANDY);
				sell_p = money_t'(`PKM_SELL_CANDY);
			end
			ITEM_BRACER: begin
				buy_p  = money_t'(`PKM_BUY_BRACER);
				sell_p = money_t'(`PKM_SELL_BRACER);
			end
			ITEM_WATER_STONE, ITEM_FIRE_STONE, ITEM_THUNDER_STONE: begin
				buy_p  = money_t'(`PKM_BUY_STONE);
				sell_p = money_t'(`PKM_SELL_STONE);
			end
			default: begin   // no item, nothing to pay
				buy_p  = '0;
				sell_p = '0;
			end
		endcase
	end

	assign price = sell ? sell_p : buy_p;

endmodule

// File: rtl/bag_ledger.sv
`timescale 1ns/1ps
`include "pkm_config.svh"

module bag_ledger (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             rec_load,
	input  pkm_pkg::bag_t    rec_bag,
	input  logic             exec,
	input  pkm_pkg::action_e action,
	input  pkm_pkg::item_e   item,
	input  pkm_pkg::money_t  amount,
	output pkm_pkg::bag_t    bag,
	output pkm_pkg::err_e    err,
	output logic             ok
);
	import pkm_pkg::*;

	localparam int STONE_LSB = `PKM_MONEY_W;
	localparam int CNT_BASE  = `PKM_MONEY_W + `PKM_STONE_W;  // bracer counter, others above

	money_t price;
	money_t money;
	stone_t stone;
	stone_t want_stone;
	count_t cnt;
	logic   has_cnt;
	logic   is_stone;
	logic [1:0] slot;    // 3 berry .. 0 bracer
	bag_t   bag_n;
	err_e   err_n;

	assign money = bag[`PKM_MONEY_W-1:0];
	assign stone = bag[STONE_LSB +: `PKM_STONE_W];

	trade_price price_i (
		.item  (item),
		.sell  (action == ACT_SELL),
		.price (price)
	);

	// which counter or stone the item refers to
	always_comb begin
		slot       = 2'd0;
		has_cnt    = 1'b0;
		is_stone   = 1'b0;
		want_stone = '0;
		case (item)
			ITEM_BERRY:         begin slot = 2'd3; has_cnt = 1'b1; end
			ITEM_MEDICINE:      begin slot = 2'd2; has_cnt = 1'b1; end
			ITEM_CANDY:         begin slot = 2'd1; has_cnt = 1'b1; end
			ITEM_BRACER:        begin slot = 2'd0; has_cnt = 1'b1; end
			ITEM_WATER_STONE:   begin is_stone = 1'b1; want_stone = stone_t'(1); end
			ITEM_FIRE_STONE:    begin is_stone = 1'b1; want_stone = stone_t'(2); end
			ITEM_THUNDER_STONE: begin is_stone = 1'b1; want_stone = stone_t'(3); end
			default: ;
		endcase
	end

	assign cnt = has_cnt ? bag[CNT_BASE + slot*`PKM_COUNT_W +: `PKM_COUNT_W] : '0;

	// ====================
	// judge the action
	// ====================
	always_comb begin
		err_n = ERR_NONE;
		bag_n = bag;
		case (action)
			ACT_BUY: begin
				if (money < price) begin
					err_n = ERR_MONEY;
				end else if (is_stone ? (stone != '0) :
					(has_cnt && cnt == count_t'(`PKM_COUNT_MAX))) begin
					err_n = ERR_FULL;
				end else begin
					bag_n[`PKM_MONEY_W-1:0] = money - price;
					if (is_stone)
						bag_n[STONE_LSB +: `PKM_STONE_W] = want_stone;
					else if (has_cnt)
						bag_n[CNT_BASE + slot*`PKM_COUNT_W +: `PKM_COUNT_W] = cnt + 1'b1;
				end
			end
			ACT_SELL: begin
				if (is_stone ? (stone != want_stone) : (cnt == '0)) begin
					err_n = ERR_NO_ITEM;   // also covers no item at all
				end else begin
					bag_n[`PKM_MONEY_W-1:0] = money + price;
					if (is_stone)
						bag_n[STONE_LSB +: `PKM_STONE_W] = '0;
					else
						bag_n[CNT_BASE + slot*`PKM_COUNT_W +: `PKM_COUNT_W] = cnt - 1'b1;
				end
			end
			ACT_DEPOSIT: bag_n[`PKM_MONEY_W-1:0] = money + amount;  // wraps at 2^14
			default: ;   // check leaves the bag alone
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			err <= ERR_NONE;
			ok  <= 1'b0;
		end else if (exec) begin
			err <= err_n;
			ok  <= (err_n == ERR_NONE);
		end
	end

	always_ff @(posedge clk) begin
		if (rec_load)
			bag <= rec_bag;
		else if (exec && err_n == ERR_NONE)
			bag <= bag_n;
	end

endmodule

// File: rtl/record_link.sv
`timescale 1ns/1ps

module record_link (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                id_valid,
	input  pkm_pkg::player_id_t id,
	input  pkm_pkg::bag_t       bag,
	input  logic                c_out_valid,
	input  pkm_pkg::record_t    c_data_r,
	output logic                busy,
	output logic                rec_load,
	output pkm_pkg::bag_t       rec_bag,
	output logic [31:0]         mon,
	output logic                c_in_valid,
	output pkm_pkg::player_id_t c_addr,
	output logic                c_r_wb,     // 1 read, 0 write
	output pkm_pkg::record_t    c_data_w
);
	import pkm_pkg::*;

	player_id_t cur_id;    // id of the player being loaded or held
	logic       held;
	logic       wb_pend;   // write-back in flight, read still to come

	// ====================
	// control
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			held       <= 1'b0;
			wb_pend    <= 1'b0;
			rec_load   <= 1'b0;
			c_in_valid <= 1'b0;
		end else begin
			c_in_valid <= 1'b0;
			rec_load   <= 1'b0;
			if (id_valid) begin
				busy       <= 1'b1;
				wb_pend    <= held;
				c_in_valid <= 1'b1;   // write-back if held, else the read
			end else if (c_out_valid && wb_pend) begin
				wb_pend    <= 1'b0;
				c_in_valid <= 1'b1;   // old record is home, now fetch the new one
			end else if (c_out_valid && busy) begin
				busy     <= 1'b0;
				held     <= 1'b1;
				rec_load <= 1'b1;
			end
		end
	end

	// ====================
	// request and record payload
	// ====================
	always_ff @(posedge clk) begin
		if (id_valid) begin
			cur_id   <= id;
			c_addr   <= held ? cur_id : id;
			c_r_wb   <= ~held;
			c_data_w <= {mon, bag};   // live bag, untouched monster word
		end else if (c_out_valid && wb_pend) begin
			c_addr <= cur_id;
			c_r_wb <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (c_out_valid && busy && !wb_pend) begin
			mon     <= c_data_r[63:32];
			rec_bag <= c_data_r[31:0];
		end
	end

endmodule

// File: rtl/action_fsm.sv
`timescale 1ns/1ps
`include "pkm_config.svh"

module action_fsm (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   act_valid,
	input  logic                   item_valid,
	input  logic                   amnt_valid,
	input  logic                   busy,
	input  logic [`PKM_DATA_W-1:0] d,
	input  pkm_pkg::bag_t          bag,
	input  logic [31:0]            mon,
	input  pkm_pkg::err_e          err,
	input  logic                   ok,
	output pkm_pkg::action_e       action,
	output pkm_pkg::item_e         item,
	output pkm_pkg::money_t        amount,
	output logic                   exec,
	output logic                   out_valid,
	output logic                   complete,
	output pkm_pkg::err_e          err_msg,
	output pkm_pkg::record_t       out_info
);
	import pkm_pkg::*;

	state_e  state;
	state_e  state_n;
	action_e act_d;
	logic    arg_seen;
	logic    item_take;
	logic    amnt_take;
	logic    act_take;

	always_comb begin
		case (d[3:0])
			4'd1:    act_d = ACT_BUY;
			4'd2:    act_d = ACT_SELL;
			4'd4:    act_d = ACT_DEPOSIT;
			4'd8:    act_d = ACT_CHECK;
			default: act_d = ACT_NONE;   // unknown codes are dropped
		endcase
	end

	assign act_take  = (state == ST_IDLE) && act_valid && (act_d != ACT_NONE);
	assign item_take = (state == ST_WAIT_ARG) && item_valid &&
		(action == ACT_BUY || action == ACT_SELL);
	assign amnt_take = (state == ST_WAIT_ARG) && amnt_valid && (action == ACT_DEPOSIT);

	// ====================
	// state machine
	// ====================
	always_comb begin
		state_n = state;
		case (state)
			ST_IDLE:
				if (act_take)
					state_n = (act_d == ACT_CHECK && !busy) ? ST_EXEC : ST_WAIT_ARG;
			ST_WAIT_ARG:
				if ((arg_seen || item_take || amnt_take) && !busy)
					state_n = ST_EXEC;
			ST_EXEC:   state_n = ST_REPORT;   // exactly one cycle
			ST_REPORT: state_n = ST_IDLE;
			default:   state_n = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			action   <= ACT_NONE;
			arg_seen <= 1'b0;
		end else begin
			state <= state_n;
			if (act_take) begin
				action   <= act_d;
				arg_seen <= (act_d == ACT_CHECK);  // check takes no argument
			end else if (item_take || amnt_take) begin
				arg_seen <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (item_take)
			item <= (d[3:0] <= 4'd7) ? item_e'(d[3:0]) : ITEM_NONE;
		if (amnt_take)
			amount <= d[`PKM_MONEY_W-1:0];
	end

	// result strobe straight off the ledger registers
	assign exec      = (state == ST_EXEC);
	assign out_valid = (state == ST_REPORT);
	assign complete  = out_valid && ok;
	assign err_msg   = out_valid ? err : ERR_NONE;
	assign out_info  = complete ? {mon, bag} : '0;

endmodule

// File: rtl/pkm_shop.sv
`timescale 1ns/1ps
`include "pkm_config.svh"

module pkm_shop (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   id_valid,
	input  logic                   act_valid,
	input  logic                   item_valid,
	input  logic                   amnt_valid,
	input  logic [`PKM_DATA_W-1:0] d,
	output logic                   out_valid,
	output logic                   complete,
	output pkm_pkg::err_e          err_msg,
	output pkm_pkg::record_t       out_info,
	// dram bridge
	output logic                   c_in_valid,
	output pkm_pkg::player_id_t    c_addr,
	output logic                   c_r_wb,
	output pkm_pkg::record_t       c_data_w,
	input  logic                   c_out_valid,
	input  pkm_pkg::record_t       c_data_r
);
	import pkm_pkg::*;

	bag_t        bag;
	bag_t        rec_bag;
	logic [31:0] mon;
	logic        rec_load;
	logic        busy;
	logic        exec;
	action_e     action;
	item_e       item;
	money_t      amount;
	err_e        err;
	logic        ok;

	bag_ledger bag_ledger_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.rec_load (rec_load),
		.rec_bag  (rec_bag),
		.exec     (exec),
		.action   (action),
		.item     (item),
		.amount   (amount),
		.bag      (bag),
		.err      (err),
		.ok       (ok)
	);

	record_link record_link_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.id_valid    (id_valid),
		.id          (d[`PKM_ID_W-1:0]),   // id sits in the low bits of d
		.bag         (bag),
		.c_out_valid (c_out_valid),
		.c_data_r    (c_data_r),
		.busy        (busy),
		.rec_load    (rec_load),
		.rec_bag     (rec_bag),
		.mon         (mon),
		.c_in_valid  (c_in_valid),
		.c_addr      (c_addr),
		.c_r_wb      (c_r_wb),
		.c_data_w    (c_data_w)
	);

	action_fsm action_fsm_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.act_valid  (act_valid),
		.item_valid (item_valid),
		.amnt_valid (amnt_valid),
		.busy       (busy),
		.d          (d),
		.bag        (bag),
		.mon        (mon),
		.err        (err),
		.ok         (ok),
		.action     (action),
		.item       (item),
		.amount     (amount),
		.exec       (exec),
		.out_valid  (out_valid),
		.complete   (complete),
		.err_msg    (err_msg),
		.out_info   (out_info)
	);

endmodule

// File: tb/bridge_model.sv
`timescale 1ns/1ps

module bridge_model (
	input  logic                clk,
	input  logic                c_in_valid,
	input  pkm_pkg::player_id_t c_addr,
	input  logic                c_r_wb,
	input  pkm_pkg::record_t    c_data_w,
	output logic                c_out_valid,
	output pkm_pkg::record_t    c_data_r
);
	import pkm_pkg::*;

	record_t    mem [0:255];
	integer     seed;
	int         delay_left;   // cycles until the reply, 0 when idle
	player_id_t req_addr;
	logic       req_read;
	record_t    req_data;

	initial begin
		seed = 17;
		for (int a = 0; a < 256; a++)
			mem[a] = {$random(seed), $random(seed)};
		delay_left  = 0;
		c_out_valid = 1'b0;
		c_data_r    = '0;
	end

	// one request at a time, reply after 1 to 8 cycles
	always @(posedge clk) begin
		c_out_valid <= 1'b0;
		if (c_in_valid) begin
			req_addr   <= c_addr;
			req_read   <= c_r_wb;
			req_data   <= c_data_w;
			delay_left <= 1 + int'({$random(seed)} % 8);
		end else if (delay_left == 1) begin
			if (!req_read)
				mem[req_addr] <= req_data;
			c_data_r    <= req_read ? mem[req_addr] : req_data;
			c_out_valid <= 1'b1;
			delay_left  <= 0;
		end else if (delay_left > 1) begin
			delay_left <= delay_left - 1;
		end
	end

endmodule

// File: tb/tb_pkm_shop.sv
`timescale 1ns/1ps
`include "pkm_config.svh"

module tb_pkm_shop;
	import pkm_pkg::*;

	logic                   clk;
	logic                   rst_n;
	logic                   id_valid;
	logic                   act_valid;
	logic                   item_valid;
	logic                   amnt_valid;
	logic [`PKM_DATA_W-1:0] d;
	logic                   out_valid;
	logic                   complete;
	err_e                   err_msg;
	record_t                out_info;
	logic                   c_in_valid;
	player_id_t             c_addr;
	logic                   c_r_wb;
	record_t                c_data_w;
	logic                   c_out_valid;
	record_t                c_data_r;

	// reference model state
	record_t     model_mem [0:255];
	count_t      cnt_m [1:4];   // berry, medicine, candy, bracer
	stone_t      stone_m;
	money_t      money_m;
	logic [31:0] mmon;
	player_id_t  cur_id;
	logic        held;

	integer  seed;
	int      checks;
	int      mismatches;
	int      timeouts;
	int      wr_count = 0;
	player_id_t wr_addr;
	record_t wr_data;
	logic    got_valid;
	logic    got_complete;
	err_e    got_err;
	record_t got_info;

	pkm_shop pkm_shop_i (.*);

	bridge_model bridge_i (
		.clk         (clk),
		.c_in_valid  (c_in_valid),
		.c_addr      (c_addr),
		.c_r_wb      (c_r_wb),
		.c_data_w    (c_data_w),
		.c_out_valid (c_out_valid),
		.c_data_r    (c_data_r)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		if (c_in_valid && !c_r_wb) begin   // write-back seen by the bridge
			wr_count <= wr_count + 1;
			wr_addr  <= c_addr;
			wr_data  <= c_data_w;
		end
	end

	// ====================
	// helpers
	// ====================
	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			mismatches++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	function automatic money_t price_of(input item_e it, input logic sell);
		int p;
		case (it)
			ITEM_BERRY:    p = sell ? `PKM_SELL_BERRY : `PKM_BUY_BERRY;
			ITEM_MEDICINE: p = sell ? `PKM_SELL_MEDICINE : `PKM_BUY_MEDICINE;
			ITEM_CANDY:    p = sell ? `PKM_SELL_CANDY : `PKM_BUY_CANDY;
			ITEM_BRACER:   p = sell ? `PKM_SELL_BRACER : `PKM_BUY_BRACER;
			ITEM_WATER_STONE, ITEM_FIRE_STONE, ITEM_THUNDER_STONE:
				p = sell ? `PKM_SELL_STONE : `PKM_BUY_STONE;
			default:       p = 0;
		endcase
		return money_t'(p);
	endfunction

	function automatic bag_t bag_now();
		return {cnt_m[1], cnt_m[2], cnt_m[3], cnt_m[4], stone_m, money_m};
	endfunction

	task automatic load_fields(input record_t r);
		mmon = r[63:32];
		{cnt_m[1], cnt_m[2], cnt_m[3], cnt_m[4], stone_m, money_m} = r[31:0];
	endtask

	task automatic model_step(input action_e act, input item_e it, input money_t amt,
			output err_e e);
		int     k;
		logic   is_gem;
		stone_t gem;
		money_t p;
		k      = int'(it);
		is_gem = (k >= 5);
		gem    = stone_t'(k - 4);   // 5..7 map to water, fire, thunder
		p      = price_of(it, act == ACT_SELL);
		e      = ERR_NONE;
		if (act == ACT_BUY) begin
			if (money_m < p)
				e = ERR_MONEY;
			else if (is_gem && stone_m != 0)
				e = ERR_FULL;
			else if (!is_gem && cnt_m[k] == `PKM_COUNT_MAX)
				e = ERR_FULL;
			else begin
				money_m = money_m - p;
				if (is_gem)
					stone_m = gem;
				else
					cnt_m[k] = cnt_m[k] + 1'b1;
			end
		end else if (act == ACT_SELL) begin
			if (is_gem ? (stone_m != gem) : (cnt_m[k] == 0))
				e = ERR_NO_ITEM;
			else begin
				money_m = money_m + p;
				if (is_gem)
					stone_m = '0;
				else
					cnt_m[k] = cnt_m[k] - 1'b1;
			end
		end else if (act == ACT_DEPOSIT) begin
			money_m = money_m + amt;   // 14-bit wrap
		end
	endtask

	task automatic send_strobe(input int which, input logic [15:0] val);
		@(posedge clk);
		d <= val;
		case (which)
			0:       id_valid <= 1'b1;
			1:       act_valid <= 1'b1;
			2:       item_valid <= 1'b1;
			default: amnt_valid <= 1'b1;
		endcase
		@(posedge clk);
		id_valid   <= 1'b0;
		act_valid  <= 1'b0;
		item_valid <= 1'b0;
		amnt_valid <= 1'b0;
	endtask

	task automatic wait_result();
		int n;
		n         = 0;
		got_valid = 1'b0;
		while (!got_valid && n < 200) begin
			@(negedge clk);
			if (out_valid) begin
				got_valid    = 1'b1;
				got_complete = complete;
				got_err      = err_msg;
				got_info     = out_info;
			end
			n++;
		end
		if (!got_valid) begin
			timeouts++;
			$display("Timeout at %0t: no out_valid within 200 cycles", $time);
		end
	endtask

	// ====================
	// operations
	// ====================
	task automatic do_action(input action_e act, input logic [15:0] arg);
		err_e e;
		send_strobe(1, 16'(act));
		if (act == ACT_BUY || act == ACT_SELL)
			send_strobe(2, arg);
		else if (act == ACT_DEPOSIT)
			send_strobe(3, arg);
		wait_result();
		model_step(act, item_e'(arg[3:0]), money_t'(arg), e);
		check_val("complete", got_complete, e == ERR_NONE);
		check_val("err_msg", got_err, e);
		check_val("out_info", got_info, (e == ERR_NONE) ? {mmon, bag_now()} : 64'h0);
	endtask

	task automatic set_money(input int target);
		do_action(ACT_DEPOSIT, 16'(money_t'(target) - money_m));
	endtask

	task automatic switch_player(input player_id_t pid);
		int         wr_before;
		logic       had;
		player_id_t old_id;
		record_t    image;
		wr_before = wr_count;
		had       = held;
		old_id    = cur_id;
		image     = {mmon, bag_now()};
		if (held)
			model_mem[cur_id] = image;
		send_strobe(0, 16'(pid));
		cur_id = pid;
		held   = 1'b1;
		load_fields(model_mem[pid]);
		do_action(ACT_CHECK, 16'h0);
		if (had) begin
			check_val("write-back count", wr_count - wr_before, 1);
			check_val("c_addr", wr_addr, old_id);
			check_val("c_data_w", wr_data, image);
		end else begin
			check_val("write-back count", wr_count - wr_before, 0);
		end
	endtask

	initial begin
		int         s;
		player_id_t pa;
		player_id_t pb;
		clk        = 1'b0;
		rst_n      = 1'b0;
		id_valid   = 1'b0;
		act_valid  = 1'b0;
		item_valid = 1'b0;
		amnt_valid = 1'b0;
		d          = '0;
		seed       = 17;
		checks     = 0;
		mismatches = 0;
		timeouts   = 0;
		held       = 1'b0;
		cur_id     = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		for (int a = 0; a < 256; a++)
			model_mem[a] = bridge_i.mem[a];

		// quiet until the first id
		repeat (6) begin
			@(negedge clk);
			check_val("out_valid", out_valid, 0);
			check_val("complete", complete, 0);
			check_val("c_in_valid", c_in_valid, 0);
		end

		pa = player_id_t'($random(seed));
		pb = pa ^ 8'h5a;
		switch_player(pa);

		// empty the stone slot so that the stone buy can succeed
		if (stone_m != '0)
			do_action(ACT_SELL, 16'(4 + int'(stone_m)));

		// buy a stone, berries up to the ceiling and then too dear an item
		set_money(1300);
		do_action(ACT_BUY, 16'(ITEM_FIRE_STONE));
		do_action(ACT_BUY, 16'(ITEM_WATER_STONE));
		repeat (16) do_action(ACT_BUY, 16'(ITEM_BERRY));
		set_money(100);
		do_action(ACT_BUY, 16'(ITEM_CANDY));

		// sell a held item, bracers down to none and the wrong and right stone
		do_action(ACT_SELL, 16'(ITEM_BERRY));
		repeat (16) do_action(ACT_SELL, 16'(ITEM_BRACER));
		s = int'(stone_m);
		do_action(ACT_SELL, 16'(5 + (s % 3)));
		do_action(ACT_SELL, 16'(4 + s));
		do_action(ACT_SELL, 16'(4 + s));

		repeat (6) do_action(ACT_DEPOSIT, 16'($random(seed)) & 16'h3fff);

		// away and back again
		switch_player(pb);
		do_action(ACT_DEPOSIT, 16'($random(seed)) & 16'h3fff);
		do_action(ACT_BUY, 16'(ITEM_BERRY));
		switch_player(pa);

		$display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+rtl
rtl/pkm_pkg.sv
rtl/trade_price.sv
rtl/bag_ledger.sv
rtl/record_link.sv
rtl/action_fsm.sv
rtl/pkm_shop.sv
tb/bridge_model.sv
tb/tb_pkm_shop.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_pkm_shop -f list.f -o sim_pkm
	./obj_dir/sim_pkm | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
